// File: files.f
hdl/pacman_pkg.sv
hdl/keyboard_process.sv
hdl/pacman_loc_ctrl.sv
hdl/map_ram.sv
hdl/tile_pixel_gen.sv
hdl/pacman_core.sv
tests/pacman_core_assertions.sv
tests/tb_pacman_core.sv

// File: Makefile
VERILATOR  ?= verilator
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert
TOP        = tb_pacman_core
FILELIST   = files.f
BUILD_DIR  = obj_dir
LOG        = sim.log
RUN_ARGS   = +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/tb_pacman_core.sv
`default_nettype none

module tb_pacman_core import pacman_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int WAIT_LIMIT = 200;
	localparam int STEP_LIMIT = 20;
	localparam int RENDER_POINTS = 150;

	logic CLOCK_50;
	logic rst_n;
	logic [7:0] scan_code;
	logic code_valid;
	logic make_break;
	logic start;
	logic step_tick;
	logic [9:0] pix_x;
	logic [8:0] pix_y;
	logic [7:0] r;
	logic [7:0] g;
	logic [7:0] b;
	logic [COL_W-1:0] pac_x;
	logic [ROW_W-1:0] pac_y;
	logic [15:0] pill_count;
	logic busy;
	logic move_done;
	logic move_blocked;

	// reference copy of the tile map and player state
	logic [TILE_BITS-1:0] model_map [0:MAP_ROWS-1][0:MAP_COLS-1];
	int model_x;
	int model_y;
	int model_pills;
	int dir_dx;
	int dir_dy;
	integer seed;

	pacman_core i_pacman_core (
		.CLOCK_50(CLOCK_50),
		.rst_n(rst_n),
		.scan_code(scan_code),
		.code_valid(code_valid),
		.make_break(make_break),
		.start(start),
		.step_tick(step_tick),
		.pix_x(pix_x),
		.pix_y(pix_y),
		.r(r),
		.g(g),
		.b(b),
		.pac_x(pac_x),
		.pac_y(pac_y),
		.pill_count(pill_count),
		.busy(busy),
		.move_done(move_done),
		.move_blocked(move_blocked)
	);

	always #5 CLOCK_50 = ~CLOCK_50;

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("TEST FAIL");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			abort_run($sformatf("MISMATCH %s expected 0x%0h actual 0x%0h",
				name, expected, actual));
		end
	endtask

	// inputs change 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge CLOCK_50);
		#1;
	endtask

	function automatic logic [TILE_BITS-1:0] rule_tile(input int row, input int col);
		if (row == 0 || row == MAP_ROWS - 1 || col == 0 || col == MAP_COLS - 1) begin
			return TILE_WALL;
		end
		if (col == WALL_COL && row >= WALL_ROW_LO && row <= WALL_ROW_HI) begin
			return TILE_WALL;
		end
		if (col == int'(START_X) && row == int'(START_Y)) begin
			return TILE_PACMAN;
		end
		return TILE_PILL;
	endfunction

	task automatic build_model();
		for (int row = 0; row < MAP_ROWS; row++) begin
			for (int col = 0; col < MAP_COLS; col++) begin
				model_map[row][col] = rule_tile(row, col);
			end
		end
		model_x = int'(START_X);
		model_y = int'(START_Y);
		model_pills = 0;
	endtask

	function automatic logic [23:0] expected_color(input int px, input int py);
		int col;
		int row;
		int ox;
		int oy;
		col = px / TILE_PX;
		row = py / TILE_PX;
		ox = px % TILE_PX;
		oy = py % TILE_PX;
		if (row >= MAP_ROWS || col >= MAP_COLS) begin
			return COLOR_BLACK;
		end
		case (model_map[row][col])
			TILE_WALL: return COLOR_WALL;
			// pill dot is 4x4 in the tile centre
			TILE_PILL: begin
				if (ox >= 6 && ox <= 9 && oy >= 6 && oy <= 9) begin
					return COLOR_PILL;
				end
				return COLOR_BLACK;
			end
			TILE_PACMAN: begin
				if (ox >= 2 && ox <= 13 && oy >= 2 && oy <= 13) begin
					return COLOR_PACMAN;
				end
				return COLOR_BLACK;
			end
			default: return COLOR_BLACK;
		endcase
	endfunction

	// colour shows up two edges after the coordinate
	task automatic check_pixel(input string name, input int px, input int py);
		logic [23:0] got;
		pix_x = 10'(px);
		pix_y = 9'(py);
		next_cycle();
		next_cycle();
		got = {r, g, b};
		check_value($sformatf("%s pixel (%0d,%0d)", name, px, py),
			32'(expected_color(px, py)), 32'(got));
	endtask

	task automatic render_sweep(input string name, input int count);
		int px;
		int py;
		check_pixel(name, int'(START_X) * TILE_PX + 8, int'(START_Y) * TILE_PX + 8);
		check_pixel(name, int'(START_X) * TILE_PX + 1, int'(START_Y) * TILE_PX + 8);
		check_pixel(name, 8, 8);
		check_pixel(name, TILE_PX + 7, TILE_PX + 7);
		check_pixel(name, TILE_PX + 1, TILE_PX + 1);
		check_pixel(name, WALL_COL * TILE_PX + 5, 10 * TILE_PX + 5);
		// off the grid on the right and below
		check_pixel(name, MAP_COLS * TILE_PX + 20, 3 * TILE_PX + 8);
		check_pixel(name, 5 * TILE_PX + 8, MAP_ROWS * TILE_PX + 8);
		for (int i = 0; i < count; i++) begin
			px = int'($unsigned($random(seed)) % 640);
			py = int'($unsigned($random(seed)) % 480);
			check_pixel(name, px, py);
		end
	endtask

	task automatic wait_idle(input string name);
		int cycles;
		cycles = 0;
		@(negedge CLOCK_50);
		while (busy) begin
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				abort_run($sformatf("%s: busy stayed high for %0d cycles", name, WAIT_LIMIT));
			end
			@(negedge CLOCK_50);
		end
		next_cycle();
	endtask

	task automatic pulse_start(input string name);
		start = 1'b1;
		next_cycle();
		start = 1'b0;
		wait_idle(name);
	endtask

	task automatic send_key(input logic [7:0] code, input logic make);
		scan_code = code;
		make_break = make;
		code_valid = 1'b1;
		next_cycle();
		code_valid = 1'b0;
	endtask

	// one tick, then watch for move_done up to the step limit
	task automatic pulse_step(output logic seen_done, output logic seen_blocked);
		int cycles;
		seen_done = 1'b0;
		seen_blocked = 1'b0;
		cycles = 0;
		step_tick = 1'b1;
		next_cycle();
		step_tick = 1'b0;
		while (!seen_done && cycles < STEP_LIMIT) begin
			@(negedge CLOCK_50);
			if (move_done) begin
				seen_done = 1'b1;
				seen_blocked = move_blocked;
			end
			cycles++;
		end
		next_cycle();
	endtask

	task automatic check_position(input string name);
		check_value($sformatf("%s pac_x", name), 32'(model_x), 32'(pac_x));
		check_value($sformatf("%s pac_y", name), 32'(model_y), 32'(pac_y));
		check_value($sformatf("%s pill_count", name), 32'(model_pills), 32'(pill_count));
	endtask

	task automatic move_and_check(input string name, output logic blocked);
		int tx;
		int ty;
		logic exp_blocked;
		logic done_seen;
		tx = model_x + dir_dx;
		ty = model_y + dir_dy;
		exp_blocked = (model_map[ty][tx] == TILE_WALL);
		pulse_step(done_seen, blocked);
		if (!done_seen) begin
			abort_run($sformatf("%s: no move_done within %0d cycles", name, STEP_LIMIT));
		end
		if (!exp_blocked) begin
			if (model_map[ty][tx] == TILE_PILL) begin
				model_pills++;
			end
			model_map[model_y][model_x] = TILE_EMPTY;
			model_map[ty][tx] = TILE_PACMAN;
			model_x = tx;
			model_y = ty;
		end
		check_value($sformatf("%s move_blocked", name), 32'(exp_blocked), 32'(blocked));
		check_position(name);
	endtask

	always @(negedge CLOCK_50) begin
		if (i_pacman_core.u_assertions.fired) begin
			abort_run("a concurrent assertion on pacman_core failed");
		end
	end

	initial begin
		logic done_seen;
		logic blocked_seen;
		int start_pills;
		seed = 32'ha2c9_f01f;
		CLOCK_50 = 1'b0;
		rst_n = 1'b0;
		scan_code = 8'h00;
		code_valid = 1'b0;
		make_break = 1'b0;
		start = 1'b0;
		step_tick = 1'b0;
		pix_x = '0;
		pix_y = '0;
		dir_dx = 0;
		dir_dy = 0;
		build_model();
		repeat (4) @(posedge CLOCK_50);
		#1;
		rst_n = 1'b1;

		// reset values
		check_value("reset busy", 32'd0, 32'(busy));
		check_value("reset move_done", 32'd0, 32'(move_done));
		check_value("reset move_blocked", 32'd0, 32'(move_blocked));
		check_value("reset rgb", 32'd0, 32'({r, g, b}));
		check_position("reset");

		// maze build and first render
		next_cycle();
		pulse_start("maze build");
		build_model();
		check_position("after start");
		render_sweep("maze render", RENDER_POINTS);

		// one step up eats a pill
		send_key(KEY_UP, 1'b1);
		dir_dx = 0;
		dir_dy = -1;
		move_and_check("key up move", blocked_seen);
		check_value("key up pill_count", 32'd1, 32'(pill_count));
		check_pixel("vacated tile", int'(START_X) * TILE_PX + 8, int'(START_Y) * TILE_PX + 8);

		// released key gives no move
		send_key(KEY_UP, 1'b0);
		pulse_step(done_seen, blocked_seen);
		check_value("released key move_done", 32'd0, 32'(done_seen));
		check_position("released key");

		// walk left into the inner wall
		send_key(KEY_LEFT, 1'b1);
		dir_dx = -1;
		dir_dy = 0;
		while (model_x > WALL_COL + 1) begin
			move_and_check("walk left", blocked_seen);
		end
		start_pills = model_pills;
		move_and_check("wall block", blocked_seen);
		check_value("wall block flag", 32'd1, 32'(blocked_seen));
		check_value("wall block pills", 32'(start_pills), 32'(pill_count));

		// back over eaten tiles
		send_key(KEY_LEFT, 1'b0);
		send_key(KEY_RIGHT, 1'b1);
		dir_dx = 1;
		start_pills = model_pills;
		repeat (5) begin
			move_and_check("revisit right", blocked_seen);
		end
		check_value("revisit pills", 32'(start_pills), 32'(pill_count));
		render_sweep("after moves", 40);

		// restart rebuilds everything
		send_key(KEY_RIGHT, 1'b0);
		pulse_start("restart");
		build_model();
		check_position("restart");
		render_sweep("restart render", RENDER_POINTS);

		if (i_pacman_core.u_assertions.fired) begin
			abort_run("a concurrent assertion on pacman_core failed");
		end else begin
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: tests/pacman_core_assertions.sv
`default_nettype none

module pacman_core_assertions import pacman_pkg::*; (
	input logic CLOCK_50,
	input logic rst_n,
	input logic start,
	input logic step_tick,
	input logic busy,
	input logic move_done,
	input logic move_blocked,
	input logic [COL_W-1:0] pac_x,
	input logic [ROW_W-1:0] pac_y,
	input logic [15:0] pill_count
);

	timeunit 1ns;
	timeprecision 100ps;

	// position as it was in the last idle cycle
	logic [COL_W-1:0] prev_x;
	logic [ROW_W-1:0] prev_y;
	logic one_step;

	logic done_err = 1'b0;
	logic count_err = 1'b0;
	logic step_err = 1'b0;
	logic stay_err = 1'b0;
	logic busy_err = 1'b0;
	logic fired;

	always_ff @(posedge CLOCK_50) begin
		if (!busy) begin
			prev_x <= pac_x;
			prev_y <= pac_y;
		end
	end

	assign one_step = (pac_y == prev_y && (pac_x == prev_x + 1'b1 || prev_x == pac_x + 1'b1)) ||
		(pac_x == prev_x && (pac_y == prev_y + 1'b1 || prev_y == pac_y + 1'b1));

	assign fired = done_err | count_err | step_err | stay_err | busy_err;

	blocked_with_done: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		move_blocked |-> move_done)
		else begin
			done_err = 1'b1;
			$error("move_blocked without move_done");
		end

	// only a start may lower the count
	count_no_drop: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		!$past(start) |-> pill_count >= $past(pill_count))
		else begin
			count_err = 1'b1;
			$error("pill_count decreased without start");
		end

	move_one_tile: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		move_done && !move_blocked |-> one_step)
		else begin
			step_err = 1'b1;
			$error("move did not shift the player by exactly one tile");
		end

	blocked_stays: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		move_blocked |-> pac_x == prev_x && pac_y == prev_y)
		else begin
			stay_err = 1'b1;
			$error("blocked move changed the position");
		end

	busy_has_cause: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		$rose(busy) |-> $past(start) || $past(step_tick))
		else begin
			busy_err = 1'b1;
			$error("busy rose without start or step_tick");
		end

endmodule

bind pacman_core pacman_core_assertions u_assertions (
	.CLOCK_50(CLOCK_50),
	.rst_n(rst_n),
	.start(start),
	.step_tick(step_tick),
	.busy(busy),
	.move_done(move_done),
	.move_blocked(move_blocked),
	.pac_x(pac_x),
	.pac_y(pac_y),
	.pill_count(pill_count)
);

`default_nettype wire

// File: hdl/pacman_core.sv
`default_nettype none

module pacman_core import pacman_pkg::*; (
	input logic CLOCK_50,
	input logic rst_n,
	input logic [7:0] scan_code,
	input logic code_valid,
	input logic make_break,
	input logic start,
	input logic step_tick,
	input logic [9:0] pix_x,
	input logic [8:0] pix_y,
	output logic [7:0] r,
	output logic [7:0] g,
	output logic [7:0] b,
	output logic [COL_W-1:0] pac_x,
	output logic [ROW_W-1:0] pac_y,
	output logic [15:0] pill_count,
	output logic busy,
	output logic move_done,
	output logic move_blocked
);

	logic up;
	logic down;
	logic left;
	logic right;

	// control side of the map
	logic [ROW_W-1:0] rdaddr;
	logic [ROW_W-1:0] wraddr;
	logic [ROW_W-1:0] addr_b;
	map_row_t wrdata;
	map_row_t redata;
	logic wren;

	// render side of the map
	logic [ROW_W-1:0] rdaddr_a;
	map_row_t q_a;

	keyboard_process keyboard_ctrl (
		.CLOCK_50(CLOCK_50),
		.rst_n(rst_n),
		.scan_code(scan_code),
		.code_valid(code_valid),
		.make_break(make_break),
		.up(up),
		.down(down),
		.left(left),
		.right(right)
	);

	pacman_loc_ctrl pac_loc (
		.CLOCK_50(CLOCK_50),
		.rst_n(rst_n),
		.start(start),
		.step_tick(step_tick),
		.up(up),
		.down(down),
		.left(left),
		.right(right),
		.redata(redata),
		.rdaddr(rdaddr),
		.wraddr(wraddr),
		.wrdata(wrdata),
		.wren(wren),
		.pac_x(pac_x),
		.pac_y(pac_y),
		.pill_count(pill_count),
		.busy(busy),
		.move_done(move_done),
		.move_blocked(move_blocked)
	);

	// port b shares one address between reads and writes
	assign addr_b = wren ? wraddr : rdaddr;

	map_ram map_mem (
		.CLOCK_50(CLOCK_50),
		.rdaddr_a(rdaddr_a),
		.q_a(q_a),
		.addr_b(addr_b),
		.data_b(wrdata),
		.wren_b(wren),
		.q_b(redata)
	);

	tile_pixel_gen pix_gen (
		.CLOCK_50(CLOCK_50),
		.rst_n(rst_n),
		.pix_x(pix_x),
		.pix_y(pix_y),
		.rdaddr_a(rdaddr_a),
		.q_a(q_a),
		.r(r),
		.g(g),
		.b(b)
	);

endmodule

`default_nettype wire

// File: hdl/tile_pixel_gen.sv
`default_nettype none

module tile_pixel_gen import pacman_pkg::*; (
	input logic CLOCK_50,
	input logic rst_n,
	input logic [9:0] pix_x,
	input logic [8:0] pix_y,
	output logic [ROW_W-1:0] rdaddr_a,
	input map_row_t q_a,
	output logic [7:0] r,
	output logic [7:0] g,
	output logic [7:0] b
);

	// stage 1 registers, aligned with q_a
	logic [COL_W-1:0] col_s1;
	logic [3:0] off_x_s1;
	logic [3:0] off_y_s1;
	logic row_ok_s1;

	logic [TILE_BITS-1:0] tile;
	logic in_pill;
	logic in_pac;
	logic [23:0] pix_color;

	// tile row goes straight to the ram
	assign rdaddr_a = ROW_W'(pix_y / TILE_PX);

	always_ff @(posedge CLOCK_50) begin
		col_s1 <= COL_W'(pix_x / TILE_PX);
		off_x_s1 <= 4'(pix_x % TILE_PX);
		off_y_s1 <= 4'(pix_y % TILE_PX);
		row_ok_s1 <= (rdaddr_a < ROW_W'(MAP_ROWS));
	end

	// stage 2 tile pick, off-grid pixels read as empty
	always_comb begin
		if (row_ok_s1 && col_s1 < COL_W'(MAP_COLS)) begin
			tile = q_a.tiles[col_s1];
		end else begin
			tile = TILE_EMPTY;
		end
	end

	assign in_pill = (off_x_s1 >= PILL_LO) && (off_x_s1 <= PILL_HI) &&
		(off_y_s1 >= PILL_LO) && (off_y_s1 <= PILL_HI);
	assign in_pac = (off_x_s1 >= PAC_LO) && (off_x_s1 <= PAC_HI) &&
		(off_y_s1 >= PAC_LO) && (off_y_s1 <= PAC_HI);

	always_comb begin
		case (tile)
			TILE_WALL: pix_color = COLOR_WALL;
			TILE_PILL: pix_color = in_pill ? COLOR_PILL : COLOR_BLACK;
			TILE_PACMAN: pix_color = in_pac ? COLOR_PACMAN : COLOR_BLACK;
			default: pix_color = COLOR_BLACK;
		endcase
	end

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			r <= '0;
			g <= '0;
			b <= '0;
		end else begin
			r <= pix_color[23:16];
			g <= pix_color[15:8];
			b <= pix_color[7:0];
		end
	end

endmodule

`default_nettype wire

// File: hdl/map_ram.sv
`default_nettype none

module map_ram import pacman_pkg::*; (
	input logic CLOCK_50,
	input logic [ROW_W-1:0] rdaddr_a,
	output map_row_t q_a,
	input logic [ROW_W-1:0] addr_b,
	input map_row_t data_b,
	input logic wren_b,
	output map_row_t q_b
);

	// one raw word per tile row
	logic [ROW_BITS-1:0] mem [0:MAP_ROWS-1];

	// render port, read only
	always_ff @(posedge CLOCK_50) begin
		q_a.raw <= mem[rdaddr_a];
	end

	// control port, read before write on the same address
	always_ff @(posedge CLOCK_50) begin
		if (wren_b) begin
			mem[addr_b] <= data_b.raw;
		end
		q_b.raw <= mem[addr_b];
	end

endmodule

`default_nettype wire

// File: hdl/pacman_loc_ctrl.sv
`default_nettype none

module pacman_loc_ctrl import pacman_pkg::*; (
	input logic CLOCK_50,
	input logic rst_n,
	input logic start,
	input logic step_tick,
	input logic up,
	input logic down,
	input logic left,
	input logic right,
	input map_row_t redata,
	output logic [ROW_W-1:0] rdaddr,
	output logic [ROW_W-1:0] wraddr,
	output map_row_t wrdata,
	output logic wren,
	output logic [COL_W-1:0] pac_x,
	output logic [ROW_W-1:0] pac_y,
	output logic [15:0] pill_count,
	output logic busy,
	output logic move_done,
	output logic move_blocked
);

	logic [STATE_W-1:0] state;
	logic [ROW_W-1:0] row_cnt;
	logic [COL_W-1:0] nxt_x;
	logic [ROW_W-1:0] nxt_y;
	logic [COL_W-1:0] tgt_x;
	logic [ROW_W-1:0] tgt_y;
	logic got_pill;
	logic move_req;
	map_row_t row_mod;

	// neighbour tile in the held direction
	always_comb begin
		nxt_x = pac_x;
		nxt_y = pac_y;
		if (up) begin
			nxt_y = pac_y - 1'b1;
		end else if (down) begin
			nxt_y = pac_y + 1'b1;
		end else if (left) begin
			nxt_x = pac_x - 1'b1;
		end else if (right) begin
			nxt_x = pac_x + 1'b1;
		end
	end

	assign move_req = step_tick & (up | down | left | right) & (state == ST_IDLE);
	assign busy = (state != ST_IDLE);

	// read address is set up one cycle ahead of the state that uses the row
	always_comb begin
		case (state)
			ST_IDLE: rdaddr = nxt_y;
			ST_CHECK: rdaddr = pac_y;
			default: rdaddr = tgt_y;
		endcase
	end

	// clear the old tile or place the player into the row just read
	always_comb begin
		row_mod = redata;
		if (state == ST_CLEAR) begin
			row_mod.tiles[pac_x] = TILE_EMPTY;
		end else begin
			row_mod.tiles[tgt_x] = TILE_PACMAN;
		end
	end

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			row_cnt <= '0;
			wren <= 1'b0;
			pac_x <= START_X;
			pac_y <= START_Y;
			pill_count <= '0;
			move_done <= 1'b0;
			move_blocked <= 1'b0;
		end else begin
			wren <= 1'b0;
			move_done <= 1'b0;
			move_blocked <= 1'b0;
			if (start) begin
				// restart from any state
				state <= ST_INIT;
				row_cnt <= '0;
				pill_count <= '0;
				pac_x <= START_X;
				pac_y <= START_Y;
			end else begin
				case (state)
					ST_IDLE: begin
						if (move_req) begin
							state <= ST_CHECK;
						end
					end
					ST_INIT: begin
						wren <= 1'b1;
						row_cnt <= row_cnt + 1'b1;
						if (row_cnt == ROW_W'(MAP_ROWS - 1)) begin
							state <= ST_INIT_END;
						end
					end
					// last row is written on the way out
					ST_INIT_END: state <= ST_IDLE;
					ST_CHECK: begin
						if (redata.tiles[tgt_x] == TILE_WALL) begin
							move_done <= 1'b1;
							move_blocked <= 1'b1;
							state <= ST_IDLE;
						end else begin
							state <= ST_CLEAR;
						end
					end
					ST_CLEAR: begin
						wren <= 1'b1;
						state <= ST_WR_CLEAR;
					end
					ST_WR_CLEAR: state <= ST_REREAD;
					// target row may be the row just cleared, so read it again
					ST_REREAD: state <= ST_PUT;
					ST_PUT: begin
						wren <= 1'b1;
						pac_x <= tgt_x;
						pac_y <= tgt_y;
						if (got_pill) begin
							pill_count <= pill_count + 1'b1;
						end
						state <= ST_FINISH;
					end
					ST_FINISH: begin
						move_done <= 1'b1;
						state <= ST_IDLE;
					end
					default: state <= ST_IDLE;
				endcase
			end
		end
	end

	// write port payload and move target
	always_ff @(posedge CLOCK_50) begin
		case (state)
			ST_IDLE: begin
				if (move_req) begin
					tgt_x <= nxt_x;
					tgt_y <= nxt_y;
				end
			end
			ST_INIT: begin
				wraddr <= row_cnt;
				wrdata <= maze_row(row_cnt);
			end
			ST_CHECK: got_pill <= (redata.tiles[tgt_x] == TILE_PILL);
			ST_CLEAR: begin
				wraddr <= pac_y;
				wrdata <= row_mod;
			end
			ST_PUT: begin
				wraddr <= tgt_y;
				wrdata <= row_mod;
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/keyboard_process.sv
`default_nettype none

module keyboard_process import pacman_pkg::*; (
	input logic CLOCK_50,
	input logic rst_n,
	input logic [7:0] scan_code,
	input logic code_valid,
	input logic make_break,
	output logic up,
	output logic down,
	output logic left,
	output logic right
);

	// one flag per arrow, high while the key is held
	logic up_held;
	logic down_held;
	logic left_held;
	logic right_held;

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			up_held <= 1'b0;
			down_held <= 1'b0;
			left_held <= 1'b0;
			right_held <= 1'b0;
		end else if (code_valid) begin
			// make sets, break clears
			case (scan_code)
				KEY_UP: begin
					up_held <= make_break;
				end
				KEY_DOWN: begin
					down_held <= make_break;
				end
				KEY_LEFT: begin
					left_held <= make_break;
				end
				KEY_RIGHT: begin
					right_held <= make_break;
				end
				default: begin
					// other keys do not steer
				end
			endcase
		end
	end

	// up beats down beats left beats right
	assign up = up_held;
	assign down = down_held & ~up_held;
	assign left = left_held & ~up_held & ~down_held;
	assign right = right_held & ~up_held & ~down_held & ~left_held;

endmodule

`default_nettype wire

// File: hdl/pacman_pkg.sv
`default_nettype none

package pacman_pkg;

	// grid geometry
	localparam int MAP_COLS = 40;
	localparam int MAP_ROWS = 30;
	localparam int TILE_BITS = 4;
	localparam int TILE_PX = 16;
	localparam int ROW_BITS = MAP_COLS * TILE_BITS;
	localparam int COL_W = 6;
	localparam int ROW_W = 5;

	// tile codes as stored in the map
	localparam logic [TILE_BITS-1:0] TILE_EMPTY = 4'd0;
	localparam logic [TILE_BITS-1:0] TILE_WALL = 4'd1;
	localparam logic [TILE_BITS-1:0] TILE_PILL = 4'd2;
	localparam logic [TILE_BITS-1:0] TILE_PACMAN = 4'd3;

	// player start and the inner wall
	localparam logic [COL_W-1:0] START_X = 6'd20;
	localparam logic [ROW_W-1:0] START_Y = 5'd15;
	localparam int WALL_COL = 10;
	localparam int WALL_ROW_LO = 5;
	localparam int WALL_ROW_HI = 24;

	// sprite extents inside a tile
	localparam int PILL_LO = 6;
	localparam int PILL_HI = 9;
	localparam int PAC_LO = 2;
	localparam int PAC_HI = 13;

	// 24-bit rgb
	localparam logic [23:0] COLOR_WALL = 24'h2121de;
	localparam logic [23:0] COLOR_PILL = 24'hffb8ae;
	localparam logic [23:0] COLOR_PACMAN = 24'hffff00;
	localparam logic [23:0] COLOR_BLACK = 24'h000000;

	// ps/2 set 2 arrow codes, E0 prefix dropped
	localparam logic [7:0] KEY_UP = 8'h75;
	localparam logic [7:0] KEY_DOWN = 8'h72;
	localparam logic [7:0] KEY_LEFT = 8'h6b;
	localparam logic [7:0] KEY_RIGHT = 8'h74;

	// player controller FSM encodings
	localparam int STATE_W = 4;
	localparam logic [STATE_W-1:0] ST_IDLE = 4'd0;
	localparam logic [STATE_W-1:0] ST_INIT = 4'd1;
	localparam logic [STATE_W-1:0] ST_INIT_END = 4'd2;
	localparam logic [STATE_W-1:0] ST_CHECK = 4'd3;
	localparam logic [STATE_W-1:0] ST_CLEAR = 4'd4;
	localparam logic [STATE_W-1:0] ST_WR_CLEAR = 4'd5;
	localparam logic [STATE_W-1:0] ST_REREAD = 4'd6;
	localparam logic [STATE_W-1:0] ST_PUT = 4'd7;
	localparam logic [STATE_W-1:0] ST_FINISH = 4'd8;

	// one map row, tile 0 in the top nibble
	typedef union packed {
		logic [ROW_BITS-1:0] raw;
		logic [0:MAP_COLS-1][TILE_BITS-1:0] tiles;
	} map_row_t;

	// maze rule for one row
	function automatic map_row_t maze_row(input logic [ROW_W-1:0] row);
		map_row_t word;
		for (int c = 0; c < MAP_COLS; c++) begin
			if (row == 0 || row == MAP_ROWS - 1 || c == 0 || c == MAP_COLS - 1 ||
				(c == WALL_COL && row >= WALL_ROW_LO && row <= WALL_ROW_HI)) begin
				word.tiles[c] = TILE_WALL;
			end else if (c == START_X && row == START_Y) begin
				word.tiles[c] = TILE_PACMAN;
			end else begin
				word.tiles[c] = TILE_PILL;
			end
		end
		return word;
	endfunction

endpackage

`default_nettype wire
